// File: hw/c16_mem_config.svh
// Bus widths, RAM depth, bank register page and BASIC pointer addresses
`ifndef C16_MEM_CONFIG_SVH
`define C16_MEM_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus sizes
//////////////////////////////////////////////////////////////////////

// CPU address and data width
`define C16_ADDR_W 16
`define C16_DATA_W 8

// Full 64K of main RAM
`define C16_RAM_DEPTH 65536

//////////////////////////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////////////////////////

// Upper 12 address bits of the Plus/4 ROM bank latch page
`define C16_BANK_PAGE 12'hFDD

// Page that always maps to KERNAL, whatever the bank
`define C16_KERNAL_PAGE 8'hFC

// Low bytes of the BASIC pointer pairs, fixed up after a PRG load
`define C16_PTR_ADDR0 16'h002D
`define C16_PTR_ADDR1 16'h002F
`define C16_PTR_ADDR2 16'h0031
`define C16_PTR_ADDR3 16'h009D

`endif

// File: hw/c16_mem_pkg.sv
// Package with the memory bus structs, bank select union and read source enum
`include "c16_mem_config.svh"

package c16_mem_pkg;

	// One access to the single RAM port
	typedef struct packed {
		logic                    valid;
		logic                    we;
		logic [`C16_ADDR_W-1:0] addr;
		logic [`C16_DATA_W-1:0] wdata;
	} mem_req_t;

	// CPU bus cycle as seen by the memory side
	typedef struct packed {
		logic                    req;
		logic                    we;
		logic [`C16_ADDR_W-1:0] addr;
		logic [`C16_DATA_W-1:0] wdata;
	} cpu_bus_t;

	// Download byte and its strobe
	typedef struct packed {
		logic                    wr;
		logic [`C16_DATA_W-1:0] data;
	} dl_byte_t;

	// Low nibble of an FDDx write, taken as-is or split into the two bank fields
	typedef union packed {
		logic [3:0] raw;
		struct packed {
			logic [1:0] romh;
			logic [1:0] roml;
		} sel;
	} bank_sel_u;

	// Which memory answers a CPU read
	typedef enum logic [2:0] {
		SRC_RAM,
		SRC_BASIC,
		SRC_KERNAL,
		SRC_FUNC_LO,
		SRC_FUNC_HI,
		SRC_CART_LO,
		SRC_CART_HI,
		SRC_NONE
	} mem_src_e;

endpackage

// File: hw/prg_loader.sv
// PRG download parser with RAM write requests and BASIC pointer fixup
`timescale 1ns/100ps
`include "c16_mem_config.svh"

module prg_loader
	import c16_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  dl_byte_t dl_i,
	input  logic     dl_active_i,
	output logic     dl_wait_o,
	output mem_req_t req_o,
	input  logic     gnt_i
);

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_DATA,
		ST_FIX
	} ldr_state_e;

	ldr_state_e             state;
	logic [1:0]             hdr_cnt;
	logic                   dl_seen;
	logic [2:0]             ptr_idx;
	logic [2:0]             ptr_next;
	logic [`C16_ADDR_W-1:0] next_addr;

	// Pointer pair base by index, odd index is the high byte
	function automatic logic [`C16_ADDR_W-1:0] ptr_addr(input logic [2:0] idx);
		logic [`C16_ADDR_W-1:0] base;
		case (idx[2:1])
			2'd0:    base = `C16_PTR_ADDR0;
			2'd1:    base = `C16_PTR_ADDR1;
			2'd2:    base = `C16_PTR_ADDR2;
			default: base = `C16_PTR_ADDR3;
		endcase
		return base + {{(`C16_ADDR_W-1){1'b0}}, idx[0]};
	endfunction

	assign ptr_next = ptr_idx + 3'd1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= ST_LOAD;
			hdr_cnt     <= 2'd0;
			dl_seen     <= 1'b0;
			ptr_idx     <= 3'd0;
			req_o.valid <= 1'b0;
			dl_wait_o   <= 1'b0;
		end else begin
			case (state)
				ST_LOAD: begin
					if (dl_active_i) begin
						dl_seen <= 1'b1;
						if (dl_i.wr) begin
							// First two bytes carry the load address, little endian
							if (hdr_cnt == 2'd0) begin
								next_addr[7:0] <= dl_i.data;
								hdr_cnt        <= 2'd1;
							end else if (hdr_cnt == 2'd1) begin
								next_addr[15:8] <= dl_i.data;
								hdr_cnt         <= 2'd2;
							end else begin
								req_o.valid <= 1'b1;
								req_o.we    <= 1'b1;
								req_o.addr  <= next_addr;
								req_o.wdata <= dl_i.data;
								next_addr   <= next_addr + 1'b1;
								dl_wait_o   <= 1'b1;
								state       <= ST_DATA;
							end
						end
					end else if (dl_seen) begin
						// Download over, next_addr now holds the end address
						dl_seen     <= 1'b0;
						hdr_cnt     <= 2'd0;
						ptr_idx     <= 3'd0;
						req_o.valid <= 1'b1;
						req_o.we    <= 1'b1;
						req_o.addr  <= ptr_addr(3'd0);
						req_o.wdata <= next_addr[7:0];
						dl_wait_o   <= 1'b1;
						state       <= ST_FIX;
					end
				end
				ST_DATA: begin
					if (gnt_i) begin
						req_o.valid <= 1'b0;
						dl_wait_o   <= 1'b0;
						state       <= ST_LOAD;
					end
				end
				default: begin
					if (gnt_i) begin
						if (ptr_idx == 3'd7) begin
							req_o.valid <= 1'b0;
							dl_wait_o   <= 1'b0;
							state       <= ST_LOAD;
						end else begin
							ptr_idx     <= ptr_next;
							req_o.addr  <= ptr_addr(ptr_next);
							req_o.wdata <= ptr_next[0] ? next_addr[15:8] : next_addr[7:0];
						end
					end
				end
			endcase
		end
	end

endmodule

// File: hw/mem_arbiter.sv
// Fixed-priority arbiter sharing the RAM port between CPU and loader
`timescale 1ns/100ps

module mem_arbiter
	import c16_mem_pkg::*;
(
	input  cpu_bus_t cpu_i,
	input  mem_req_t ldr_req_i,
	output logic     ldr_gnt_o,
	output mem_req_t ram_req_o
);

	//////////////////////////////////////////////////////////////////////
	// Port select
	//////////////////////////////////////////////////////////////////////

	// CPU always wins, its access has a fixed one-cycle reply
	always_comb begin
		if (cpu_i.req) begin
			ram_req_o.valid = 1'b1;
			ram_req_o.we    = cpu_i.we;
			ram_req_o.addr  = cpu_i.addr;
			ram_req_o.wdata = cpu_i.wdata;
		end else begin
			ram_req_o = ldr_req_i;
		end
	end

	// Loader is granted only when its request is the one reaching the RAM
	assign ldr_gnt_o = ldr_req_i.valid & ~cpu_i.req;

endmodule

// File: hw/main_ram.sv
// Single-port synchronous main RAM with registered read
`timescale 1ns/100ps
`include "c16_mem_config.svh"

module main_ram
	import c16_mem_pkg::*;
(
	input  logic                   clk_sys,
	input  mem_req_t               req_i,
	output logic [`C16_DATA_W-1:0] rdata_o
);

	logic [`C16_DATA_W-1:0] mem [`C16_RAM_DEPTH];

	// Writes land on this edge, reads show up one cycle later
	always_ff @(posedge clk_sys) begin
		if (req_i.valid) begin
			if (req_i.we) begin
				mem[req_i.addr] <= req_i.wdata;
			end else begin
				rdata_o <= mem[req_i.addr];
			end
		end
	end

endmodule

// File: hw/rom_bank_ctrl.sv
// Plus/4 ROM bank register and CPU read source decoder
`timescale 1ns/100ps
`include "c16_mem_config.svh"

module rom_bank_ctrl
	import c16_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     model_i,
	input  cpu_bus_t cpu_i,
	output mem_src_e src_o
);

	localparam int unsigned AW = `C16_ADDR_W;

	logic      model_q;
	bank_sel_u bank_q;
	mem_src_e  src_next;

	// Model latched while in reset, bank latch only exists on the Plus/4
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model_i;
			bank_q  <= '0;
		end else if (model_q && cpu_i.req && cpu_i.we &&
			     cpu_i.addr[AW-1:4] == `C16_BANK_PAGE) begin
			bank_q.raw <= cpu_i.addr[3:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read source decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (!cpu_i.addr[AW-1]) begin
			src_next = SRC_RAM;
		end else if (!cpu_i.addr[AW-2]) begin
			// 8000-BFFF, low ROM window
			case (bank_q.sel.roml)
				2'd0:    src_next = SRC_BASIC;
				2'd1:    src_next = SRC_CART_LO;
				2'd2:    src_next = SRC_FUNC_LO;
				default: src_next = SRC_NONE;
			endcase
		end else if (cpu_i.addr[AW-1:8] == `C16_KERNAL_PAGE) begin
			src_next = SRC_KERNAL;
		end else begin
			// C000 and up, high ROM window
			case (bank_q.sel.romh)
				2'd0:    src_next = SRC_KERNAL;
				2'd1:    src_next = SRC_CART_HI;
				2'd2:    src_next = SRC_FUNC_HI;
				default: src_next = SRC_NONE;
			endcase
		end
	end

	// Source lines up with the RAM read data, one cycle after the request
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src_o <= SRC_NONE;
		end else if (cpu_i.req && !cpu_i.we) begin
			src_o <= src_next;
		end
	end

endmodule

// File: hw/c16_mem_top.sv
// Memory subsystem top with PRG loader, arbiter, main RAM and bank controller
`timescale 1ns/100ps
`include "c16_mem_config.svh"

module c16_mem_top
	import c16_mem_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   model_i,
	input  dl_byte_t               dl_i,
	input  logic                   dl_active_i,
	output logic                   dl_wait_o,
	input  cpu_bus_t               cpu_i,
	output logic [`C16_DATA_W-1:0] rdata_o,
	output mem_src_e               src_o
);

	mem_req_t ldr_req;
	logic     ldr_gnt;
	mem_req_t ram_req;

	//////////////////////////////////////////////////////////////////////
	// Download path
	//////////////////////////////////////////////////////////////////////

	prg_loader i_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_i        (dl_i),
		.dl_active_i (dl_active_i),
		.dl_wait_o   (dl_wait_o),
		.req_o       (ldr_req),
		.gnt_i       (ldr_gnt)
	);

	// CPU has priority over the loader
	mem_arbiter i_arb (
		.cpu_i     (cpu_i),
		.ldr_req_i (ldr_req),
		.ldr_gnt_o (ldr_gnt),
		.ram_req_o (ram_req)
	);

	//////////////////////////////////////////////////////////////////////
	// Memory and ROM banking
	//////////////////////////////////////////////////////////////////////

	main_ram i_ram (
		.clk_sys (clk_sys),
		.req_i   (ram_req),
		.rdata_o (rdata_o)
	);

	rom_bank_ctrl i_bank (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model_i (model_i),
		.cpu_i   (cpu_i),
		.src_o   (src_o)
	);

endmodule

// File: tests/tb_c16_mem.sv
// Trace-driven testbench for the C16 memory subsystem with driver, compare and watchdog tasks
`timescale 1ns/100ps
`include "c16_mem_config.svh"

module tb_c16_mem
	import c16_mem_pkg::*;
();

	logic                   clk_sys;
	logic                   reset;
	logic                   model_i;
	dl_byte_t               dl_i;
	logic                   dl_active_i;
	logic                   dl_wait_o;
	cpu_bus_t               cpu_i;
	logic [`C16_DATA_W-1:0] rdata_o;
	mem_src_e               src_o;

	integer                 fd;
	integer                 rc;
	integer                 line_cnt;
	integer                 seed = 32'h99c3;
	integer                 wd_cycles = 0;
	logic [63:0]            op;
	logic [8*256-1:0]       line_buf;
	logic [`C16_ADDR_W-1:0] addr;
	logic [`C16_DATA_W-1:0] data;
	logic [`C16_DATA_W-1:0] exp_byte;
	logic [2:0]             src_val;

	c16_mem_top i_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model_i     (model_i),
		.dl_i        (dl_i),
		.dl_active_i (dl_active_i),
		.dl_wait_o   (dl_wait_o),
		.cpu_i       (cpu_i),
		.rdata_o     (rdata_o),
		.src_o       (src_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Error handling and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_byte(input string name, input logic [`C16_DATA_W-1:0] got,
				  input logic [`C16_DATA_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_src(input mem_src_e got, input mem_src_e exp);
		if (got !== exp)
			fail_run($sformatf("FAIL src_o: got %h expected %h", got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driver tasks, all inputs change on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic apply_reset(input logic model);
		@(negedge clk_sys);
		reset       = 1'b1;
		model_i     = model;
		cpu_i       = '0;
		dl_i        = '0;
		dl_active_i = 1'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic cpu_write(input logic [`C16_ADDR_W-1:0] a, input logic [`C16_DATA_W-1:0] d);
		@(negedge clk_sys);
		cpu_i = {1'b1, 1'b1, a, d};
		@(negedge clk_sys);
		cpu_i = '0;
	endtask

	// Read data and source are due one cycle after the request
	task automatic cpu_read(input logic [`C16_ADDR_W-1:0] a, input logic [`C16_DATA_W-1:0] d,
				input mem_src_e s);
		@(negedge clk_sys);
		cpu_i = {1'b1, 1'b0, a, {`C16_DATA_W{1'b0}}};
		@(negedge clk_sys);
		cpu_i = '0;
		check_byte("rdata_o", rdata_o, d);
		check_src(src_o, s);
	endtask

	task automatic send_byte(input logic [`C16_DATA_W-1:0] d);
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
		dl_i = {1'b1, d};
		@(negedge clk_sys);
		dl_i.wr = 1'b0;
		while (dl_wait_o)
			@(negedge clk_sys);
	endtask

	// Download byte with CPU reads thrown into random cycles of the wait
	task automatic send_byte_busy(input logic [`C16_DATA_W-1:0] d,
				      input logic [`C16_ADDR_W-1:0] ra,
				      input logic [`C16_DATA_W-1:0] rd);
		logic pending;
		logic done;
		pending = 1'b0;
		done    = 1'b0;
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
		dl_i = {1'b1, d};
		@(negedge clk_sys);
		dl_i.wr = 1'b0;
		// Data byte raises the wait in the cycle after it is taken
		check_flag("dl_wait_o", dl_wait_o, 1'b1);
		while (!done) begin
			if (pending) begin
				check_byte("rdata_o", rdata_o, rd);
				check_src(src_o, SRC_RAM);
				// Loader stays held off while the CPU owns the port
				check_flag("dl_wait_o", dl_wait_o, 1'b1);
			end
			if (dl_wait_o) begin
				pending = $random(seed) & 1;
				cpu_i   = pending ? {1'b1, 1'b0, ra, {`C16_DATA_W{1'b0}}} : '0;
				@(negedge clk_sys);
			end else begin
				cpu_i = '0;
				done  = 1'b1;
			end
		end
	endtask

	// End of download, then the pointer fixup runs until dl_wait_o drops
	task automatic end_download();
		@(negedge clk_sys);
		dl_active_i = 1'b0;
		@(negedge clk_sys);
		while (!dl_wait_o)
			@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
	endtask

	// Watchdog sized from the trace length
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk_sys);
		fail_run("Timeout: the trace did not complete within the watchdog limit");
	end

	initial begin
		reset       = 1'b1;
		model_i     = 1'b1;
		dl_i        = '0;
		dl_active_i = 1'b0;
		cpu_i       = '0;
		fd = $fopen("tests/c16_mem_trace.txt", "r");
		if (fd == 0)
			fail_run("Could not open the trace file tests/c16_mem_trace.txt");
		line_cnt = 0;
		rc = $fgets(line_buf, fd);
		while (rc != 0) begin
			line_cnt = line_cnt + 1;
			rc = $fgets(line_buf, fd);
		end
		$fclose(fd);
		wd_cycles = line_cnt * 40;
		fd = $fopen("tests/c16_mem_trace.txt", "r");
		while ($fscanf(fd, "%s", op) == 1) begin
			case (op)
				"#": rc = $fgets(line_buf, fd);
				"R": begin
					rc = $fscanf(fd, "%h", data);
					apply_reset(data[0]);
				end
				"W": begin
					rc = $fscanf(fd, "%h %h", addr, data);
					cpu_write(addr, data);
				end
				"C": begin
					rc = $fscanf(fd, "%h %h %h", addr, data, src_val);
					cpu_read(addr, data, mem_src_e'(src_val));
				end
				"S": begin
					@(negedge clk_sys);
					dl_active_i = 1'b1;
				end
				"B": begin
					rc = $fscanf(fd, "%h", data);
					send_byte(data);
				end
				"P": begin
					rc = $fscanf(fd, "%h %h %h", data, addr, exp_byte);
					send_byte_busy(data, addr, exp_byte);
				end
				"E": end_download();
				default: fail_run($sformatf("Unknown operation in trace file: %0s", op));
			endcase
		end
		$fclose(fd);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: tests/c16_mem_trace.txt
# Columns in hex: R model | W addr data | C addr data src | S | B data | E | P data raddr rdata
# src codes: 0 RAM 1 BASIC 2 KERNAL 3 FUNC_LO 4 FUNC_HI 5 CART_LO 6 CART_HI 7 NONE
R 1
W 1000 a5
C 1000 a5 0
W 2345 3c
C 2345 3c 0
# PRG at 1001, end address 1004
S
B 01
B 10
B 11
B 22
B 33
E
C 1001 11 0
C 1002 22 0
C 1003 33 0
C 1000 a5 0
C 002d 04 0
C 002e 10 0
C 002f 04 0
C 0030 10 0
C 0031 04 0
C 0032 10 0
C 009d 04 0
C 009e 10 0
# PRG at 3000 with CPU reads during the waits, end address 3004
S
B 00
B 30
P 5a 1000 a5
P 6b 1000 a5
P 7c 2345 3c
P 8d 2345 3c
E
C 3000 5a 0
C 3001 6b 0
C 3002 7c 0
C 3003 8d 0
C 002d 04 0
C 002e 30 0
C 009d 04 0
C 009e 30 0
# Plus/4 banking
W 9000 91
W d000 d0
W fc10 fc
C 9000 91 1
C d000 d0 2
W fdd6 00
C 9000 91 3
C d000 d0 6
C fc10 fc 2
R 1
C 9000 91 1
C d000 d0 2
# C16 ignores the bank latch
R 0
W fdd6 00
C 9000 91 1
C d000 d0 2

// File: tb.f
+incdir+hw
hw/c16_mem_pkg.sv
hw/prg_loader.sv
hw/mem_arbiter.sv
hw/main_ram.sv
hw/rom_bank_ctrl.sv
hw/c16_mem_top.sv
tests/tb_c16_mem.sv
